//--- Makefile
# Verilator flow for the ALU execution unit.
TOP ?= AluTb
SEED ?= 48202
LOG ?= sim.log
OBJDIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f build.f

sim:
	$(VERILATOR) $(VFLAGS) -Gseed=$(SEED) --top-module $(TOP) --Mdir $(OBJDIR) -f build.f
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- build.f
hdl/PkgAlu.sv
hdl/PkgAluStream.sv
hdl/AluReqIf.sv
hdl/AluRespIf.sv
hdl/AluIssue.sv
hdl/BarrelShifter.sv
hdl/Alu.sv
hdl/AluRetire.sv
hdl/AluTop.sv
dv/AluTb.sv

//--- dv/AluTb.sv
module AluTb;

	timeunit 1ns;
	timeprecision 1ps;

	import PkgAlu::*;
	import PkgAluStream::*;

	parameter int seed = 32'hbc4a;

	localparam int maxTests = 64;
	localparam int resetCycles = 16;
	localparam int cyclesPerTest = 40;
	localparam int drainCycles = 8;

	logic clk;
	logic rstN;
	logic reqValid;
	logic reqReady;
	AluOper reqOper;
	AluData reqA;
	AluData reqB;
	AluTag reqTag;
	logic respValid;
	logic respReady;
	AluData respData;
	AluTag respTag;

	// one entry per line of the vector file.
	logic [3:0] testOper [maxTests];
	AluData testA [maxTests];
	AluData testB [maxTests];
	AluData testResult [maxTests];

	int numTests;
	int numChecked;
	int passCount;
	int failCount;
	int errorCount;
	logic loaded;

	AluTop UUT
	(
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqOper(reqOper),
		.reqA(reqA),
		.reqB(reqB),
		.reqTag(reqTag),
		.respValid(respValid),
		.respReady(respReady),
		.respData(respData),
		.respTag(respTag)
	);

	always
	begin
		#50 clk = ~clk;
	end

	task automatic loadTests();
		int fd;
		int fields;
		string line;
		logic [3:0] oper;
		AluData a;
		AluData b;
		AluData result;
		numTests = 0;
		fd = $fopen("dv/aluTests.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the vector file dv/aluTests.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				if ($fgets(line, fd) > 0 && line.getc(0) != "#") // lines with # are notes.
				begin
					fields = $sscanf(line, "%h %h %h %h", oper, a, b, result);
					if (fields == 4 && numTests < maxTests)
					begin
						testOper[numTests] = oper;
						testA[numTests] = a;
						testB[numTests] = b;
						testResult[numTests] = result;
						numTests++;
					end
				end
			end
			$fclose(fd);
		end
		if (numTests == 0)
		begin
			$display("no test vectors were read");
			errorCount++;
		end
	endtask

	task automatic checkIdle(input string when);
		if (respValid !== 1'b0)
		begin
			$display("mismatch respValid %s: got %h expected 0", when, respValid);
			errorCount++;
		end
		if (reqReady !== 1'b1)
		begin
			$display("mismatch reqReady %s: got %h expected 1", when, reqReady);
			errorCount++;
		end
	endtask

	task automatic driveRequests();
		integer gapSeed;
		gapSeed = seed;
		for (int i = 0; i < numTests; i++)
		begin
			while (($random(gapSeed) & 3) == 0)
			begin
				reqValid = 1'b0;
				@(negedge clk);
			end
			reqValid = 1'b1;
			reqOper = AluOper'(testOper[i]);
			reqA = testA[i];
			reqB = testB[i];
			reqTag = AluTag'(i); // tags wrap modulo 16.
			// reqReady comes from registered state, so it has settled by now.
			while (!reqReady)
			begin
				@(negedge clk);
			end
			@(negedge clk);
		end
		reqValid = 1'b0;
	endtask

	// sets respReady for the coming edge and checks the result that edge will take.
	task automatic collectResponses();
		integer readySeed;
		AluTag wantTag;
		logic good;
		readySeed = ~seed;
		while (numChecked < numTests)
		begin
			@(negedge clk);
			respReady = (($random(readySeed) & 3) != 0);
			if (respValid && respReady)
			begin
				wantTag = AluTag'(numChecked);
				good = 1'b1;
				if (respData !== testResult[numChecked])
				begin
					$display("mismatch respData test %0d: got %h expected %h",
						numChecked, respData, testResult[numChecked]);
					good = 1'b0;
				end
				if (respTag !== wantTag)
				begin
					$display("mismatch respTag test %0d: got %h expected %h",
						numChecked, respTag, wantTag);
					good = 1'b0;
				end
				if (good)
				begin
					$display("test %0d oper %h: ok", numChecked, testOper[numChecked]);
					passCount++;
				end
				else
				begin
					failCount++;
				end
				numChecked++;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		reqValid = 1'b0;
		reqOper = Add;
		reqA = '0;
		reqB = '0;
		reqTag = '0;
		respReady = 1'b0;
		numChecked = 0;
		passCount = 0;
		failCount = 0;
		errorCount = 0;
		loaded = 1'b0;
		loadTests();
		loaded = 1'b1;

		// the first rising edge clears the state, so every falling edge shows idle ports.
		repeat (resetCycles)
		begin
			@(negedge clk);
			checkIdle("during reset");
		end
		rstN = 1'b1;
		@(negedge clk);
		checkIdle("after reset");

		fork
			driveRequests();
			collectResponses();
		join

		// a duplicated result would still be waiting here.
		respReady = 1'b1;
		repeat (drainCycles)
		begin
			@(negedge clk);
			if (respValid)
			begin
				$display("a response arrived after the last test");
				errorCount++;
			end
		end

		$display("tests passed %0d failed %0d, other errors %0d",
			passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial
	begin
		wait (loaded === 1'b1);
		repeat (resetCycles + drainCycles + numTests * cyclesPerTest)
		begin
			@(posedge clk);
		end
		$display("timeout: %0d of %0d responses never arrived",
			numTests - numChecked, numTests);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- dv/aluTests.txt
# columns: oper a b expected, all hex
# oper codes: 0 add 1 sub 2 sltu 3 slts 4 andn 5 and 6 or 7 xor 8 inva 9 lsl a lsr b asr c orn d nand e nor f xnor
0 00000005 00000007 0000000c
0 ffffffff 00000001 00000000
1 00000000 00000001 ffffffff
1 12345678 02345678 10000000
2 80000000 00000001 00000000
3 80000000 00000001 00000001
2 00000001 ffffffff 00000001
3 00000001 ffffffff 00000000
4 ffffffff 0f0f0f0f f0f0f0f0
5 ffffffff 00000000 00000000
5 a5a5a5a5 ffffffff a5a5a5a5
6 f0f0f0f0 0f0f0f0f ffffffff
7 ffffffff a5a5a5a5 5a5a5a5a
8 00000000 12345678 ffffffff
9 00000001 0000001f 80000000
9 12345678 00000004 23456780
a 80000000 0000001f 00000001
a 12345678 00000000 12345678
a 12345678 00000008 00123456
b 80000000 00000001 c0000000
b f0000000 00000004 ff000000
b 80000000 0000001f ffffffff
9 ffffffff 00000020 00000000
a ffffffff 00000100 00000000
b 80000000 ffffffff ffffffff
b 7fffffff 00000020 00000000
c 00000000 ffffffff 00000000
c 12340000 ffff0000 1234ffff
d ffffffff ffffffff 00000000
d a5a5a5a5 0f0f0f0f fafafafa
e 00000000 00000000 ffffffff
f 12345678 12345678 ffffffff

//--- hdl/Alu.sv
module Alu
(
	AluReqIf.consumer req,
	AluRespIf.producer resp
);

	import PkgAlu::*;

	logic ltu;
	logic lts;
	logic outOfRange;

	ShiftAmount amount;

	AluData lslData;
	AluData lsrData;
	AluData asrData;
	AluData signFill;

	// unsigned and signed less-than of a and b.
	assign ltu = req.a < req.b;
	assign lts = $signed(req.a) < $signed(req.b);

	// any set bit above the low five means a shift of 32 or more.
	assign outOfRange = |req.b[dataWidth-1:shiftWidth];
	assign amount = req.b[shiftWidth-1:0];

	assign signFill = {dataWidth{req.a[dataWidth-1]}};

	BarrelShifter shifter
	(
		.data(req.a),
		.amount(amount),
		.lsl(lslData),
		.lsr(lsrData),
		.asr(asrData)
	);

	// the unit has no state of its own.
	assign resp.valid = req.valid;
	assign resp.tag = req.tag;
	assign req.ready = resp.ready;

	always_comb
	begin
		case (req.oper)
			Add:
			begin
				resp.data = req.a + req.b; // wraps modulo 2^32.
			end

			Sub:
			begin
				resp.data = req.a - req.b;
			end

			Sltu:
			begin
				resp.data = {{(dataWidth - 1){1'b0}}, ltu};
			end

			Slts:
			begin
				resp.data = {{(dataWidth - 1){1'b0}}, lts};
			end

			AndN:
			begin
				resp.data = req.a & ~req.b;
			end

			And:
			begin
				resp.data = req.a & req.b;
			end

			Or:
			begin
				resp.data = req.a | req.b;
			end

			Xor:
			begin
				resp.data = req.a ^ req.b;
			end

			InvA:
			begin
				resp.data = ~req.a;
			end

			Lsl:
			begin
				if (outOfRange)
				begin
					resp.data = '0;
				end
				else
				begin
					resp.data = lslData;
				end
			end

			Lsr:
			begin
				if (outOfRange)
				begin
					resp.data = '0;
				end
				else
				begin
					resp.data = lsrData;
				end
			end

			Asr:
			begin
				// large shifts leave only copies of the sign bit.
				if (outOfRange)
				begin
					resp.data = signFill;
				end
				else
				begin
					resp.data = asrData;
				end
			end

			OrN:
			begin
				resp.data = req.a | ~req.b;
			end

			Nand:
			begin
				resp.data = ~(req.a & req.b);
			end

			Nor:
			begin
				resp.data = ~(req.a | req.b);
			end

			Xnor:
			begin
				resp.data = ~(req.a ^ req.b);
			end

			default:
			begin
				resp.data = '0;
			end
		endcase
	end

endmodule

//--- hdl/AluIssue.sv
module AluIssue
(
	input logic clk,
	input logic rstN,
	input logic reqValid,
	output logic reqReady,
	input PkgAlu::AluOper reqOper,
	input PkgAlu::AluData reqA,
	input PkgAlu::AluData reqB,
	input PkgAluStream::AluTag reqTag,
	AluReqIf.producer issue
);

	import PkgAlu::*;
	import PkgAluStream::*;

	logic full;
	logic accept;
	logic drain;

	AluOper heldOper;
	AluData heldA;
	AluData heldB;
	AluTag heldTag;

	// the held request leaves when downstream takes it this cycle.
	assign drain = full && issue.ready;

	// downstream ready comes from the retire state, so this stays registered.
	assign reqReady = !full || issue.ready;
	assign accept = reqValid && reqReady;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			full <= 1'b0;
		end
		else if (accept)
		begin
			full <= 1'b1;
		end
		else if (drain)
		begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			heldOper <= reqOper;
			heldA <= reqA;
			heldB <= reqB;
			heldTag <= reqTag;
		end
	end

	assign issue.valid = full;
	assign issue.oper = heldOper;
	assign issue.a = heldA;
	assign issue.b = heldB;
	assign issue.tag = heldTag;

endmodule

//--- hdl/AluReqIf.sv
interface AluReqIf;

	import PkgAlu::*;
	import PkgAluStream::*;

	logic valid;
	logic ready;
	AluOper oper;
	AluData a;
	AluData b;
	AluTag tag;

	// the side that offers a request.
	modport producer
	(
		output valid,
		output oper,
		output a,
		output b,
		output tag,
		input ready
	);

	// the side that takes a request.
	modport consumer
	(
		input valid,
		input oper,
		input a,
		input b,
		input tag,
		output ready
	);

endinterface

//--- hdl/AluRespIf.sv
interface AluRespIf;

	import PkgAlu::*;
	import PkgAluStream::*;

	logic valid;
	logic ready;
	AluData data;
	AluTag tag; // copied from the request.

	modport producer
	(
		output valid,
		output data,
		output tag,
		input ready
	);

	modport consumer
	(
		input valid,
		input data,
		input tag,
		output ready
	);

endinterface

//--- hdl/AluRetire.sv
module AluRetire
(
	input logic clk,
	input logic rstN,
	AluRespIf.consumer retire,
	output logic respValid,
	input logic respReady,
	output PkgAlu::AluData respData,
	output PkgAluStream::AluTag respTag
);

	import PkgAlu::*;
	import PkgAluStream::*;

	RetireState state;
	RetireState nextState;

	logic push;
	logic pop;

	// head is what the port shows, skid is the younger entry behind it.
	AluData headData;
	AluTag headTag;
	AluData skidData;
	AluTag skidTag;

	// ready depends on the registered state only.
	assign retire.ready = (state != Two);
	assign respValid = (state != Empty);

	assign push = retire.valid && retire.ready;
	assign pop = respValid && respReady;

	always_comb
	begin
		nextState = state;
		case (state)
			Empty:
			begin
				if (push)
				begin
					nextState = One;
				end
			end

			One:
			begin
				if (push && !pop)
				begin
					nextState = Two;
				end
				else if (!push && pop)
				begin
					nextState = Empty;
				end
			end

			Two:
			begin
				if (pop)
				begin
					nextState = One; // the skid entry moves up to the head.
				end
			end

			default:
			begin
				nextState = Empty;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= Empty;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == Two)
		begin
			if (pop)
			begin
				headData <= skidData;
				headTag <= skidTag;
			end
		end
		else if (push)
		begin
			// a busy head that stays keeps the new result in the skid entry.
			if (state == One && !pop)
			begin
				skidData <= retire.data;
				skidTag <= retire.tag;
			end
			else
			begin
				headData <= retire.data;
				headTag <= retire.tag;
			end
		end
	end

	assign respData = headData;
	assign respTag = headTag;

endmodule

//--- hdl/AluTop.sv
module AluTop
(
	input logic clk,
	input logic rstN,
	input logic reqValid,
	output logic reqReady,
	input PkgAlu::AluOper reqOper,
	input PkgAlu::AluData reqA,
	input PkgAlu::AluData reqB,
	input PkgAluStream::AluTag reqTag,
	output logic respValid,
	input logic respReady,
	output PkgAlu::AluData respData,
	output PkgAluStream::AluTag respTag
);

	AluReqIf reqIf();

	AluRespIf respIf();

	// registered request boundary.
	AluIssue issueStage
	(
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqOper(reqOper),
		.reqA(reqA),
		.reqB(reqB),
		.reqTag(reqTag),
		.issue(reqIf.producer)
	);

	Alu alu
	(
		.req(reqIf.consumer),
		.resp(respIf.producer)
	);

	// in-order result buffer that takes the back-pressure.
	AluRetire retireStage
	(
		.clk(clk),
		.rstN(rstN),
		.retire(respIf.consumer),
		.respValid(respValid),
		.respReady(respReady),
		.respData(respData),
		.respTag(respTag)
	);

endmodule

//--- hdl/BarrelShifter.sv
module BarrelShifter
(
	input PkgAlu::AluData data,
	input PkgAlu::ShiftAmount amount,
	output PkgAlu::AluData lsl,
	output PkgAlu::AluData lsr,
	output PkgAlu::AluData asr
);

	import PkgAlu::*;

	// entry 0 is the input, entry i holds the value after stage i.
	AluData lslStage [0:shiftWidth];
	AluData lsrStage [0:shiftWidth];
	AluData asrStage [0:shiftWidth];

	assign lslStage[0] = data;
	assign lsrStage[0] = data;
	assign asrStage[0] = data;

	for (genvar i = 0; i < shiftWidth; i++)
	begin : genStage
		localparam int step = 1 << i;

		// each stage either passes its input or moves it by step bits.
		assign lslStage[i + 1] = amount[i]
			? {lslStage[i][dataWidth-1-step:0], {step{1'b0}}}
			: lslStage[i];

		assign lsrStage[i + 1] = amount[i]
			? {{step{1'b0}}, lsrStage[i][dataWidth-1:step]}
			: lsrStage[i];

		assign asrStage[i + 1] = amount[i]
			? {{step{data[dataWidth-1]}}, asrStage[i][dataWidth-1:step]} // sign fill.
			: asrStage[i];
	end

	assign lsl = lslStage[shiftWidth];
	assign lsr = lsrStage[shiftWidth];
	assign asr = asrStage[shiftWidth];

endmodule

//--- hdl/PkgAlu.sv
package PkgAlu;

	// datapath width of the execution unit.
	localparam int dataWidth = 32;

	// bits of b that select an in-range shift.
	localparam int shiftWidth = $clog2(dataWidth);

	typedef logic [dataWidth-1:0] AluData;

	typedef logic [shiftWidth-1:0] ShiftAmount;

	// the codes are fixed, since the test data uses them directly.
	typedef enum logic [3:0]
	{
		Add = 4'd0,
		Sub = 4'd1,
		Sltu = 4'd2,
		Slts = 4'd3,
		AndN = 4'd4,
		And = 4'd5,
		Or = 4'd6,
		Xor = 4'd7,
		InvA = 4'd8,
		Lsl = 4'd9,
		Lsr = 4'd10,
		Asr = 4'd11,
		OrN = 4'd12,
		Nand = 4'd13,
		Nor = 4'd14,
		Xnor = 4'd15
	} AluOper;

endpackage

//--- hdl/PkgAluStream.sv
package PkgAluStream;

	// width of the tag that travels with each request.
	localparam int tagWidth = 4;

	typedef logic [tagWidth-1:0] AluTag;

	// fill level of the output buffer.
	typedef enum logic [1:0]
	{
		Empty = 2'd0,
		One = 2'd1,
		Two = 2'd2
	} RetireState;

endpackage
